/* include/mem_stage_defs.svh */
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// Data path and byte address width
`define XLEN 32

// Register file address width
`define REG_AW 5

`endif

/* hdl/rv_mem_pkg.sv */
`include "mem_stage_defs.svh"

package rv_mem_pkg;

    // **********************************************************************
    // Operation codes and pipeline records
    // **********************************************************************

    // Memory operation, NONE for ALU-only records
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LH   = 4'd2,
        LW   = 4'd3,
        LBU  = 4'd4,
        LHU  = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } mem_op_e;

    // Record from the execute stage
    typedef struct packed {
        mem_op_e             op;
        logic [`XLEN-1:0]    alu_result;
        logic [`XLEN-1:0]    rs2_data;
        logic                mem_to_reg;
        logic                rf_wr_en;
        logic [`REG_AW-1:0]  rd_addr;
        logic                exception;
    } ex_mem_t;

    // Access unit result, raw word still unextracted
    typedef struct packed {
        mem_op_e             op;
        logic [1:0]          byte_off;
        logic [`XLEN-1:0]    alu_result;
        logic [`XLEN-1:0]    rd_word;
        logic                mem_to_reg;
        logic                rf_wr_en;
        logic [`REG_AW-1:0]  rd_addr;
        logic                exception;
    } mem_rsp_t;

    // Writeback record
    typedef struct packed {
        logic [`XLEN-1:0]    rd_data;
        logic [`XLEN-1:0]    alu_result;
        logic                rf_wr_en;
        logic [`REG_AW-1:0]  rd_addr;
        logic                exception;
    } mem_wb_t;

    // **********************************************************************
    // Wishbone classic bus
    // **********************************************************************

    // Master to slave, adr is a word address
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [`XLEN/8-1:0]  sel;
        logic [`XLEN-3:0]    adr;
        logic [`XLEN-1:0]    dat;
    } wb_m2s_t;

    // Slave to master
    typedef struct packed {
        logic                ack;
        logic [`XLEN-1:0]    dat;
    } wb_s2m_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {LB, LH, LW, LBU, LHU};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {SB, SH, SW};
    endfunction

endpackage

/* hdl/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type T = rv_mem_pkg::ex_mem_t
) (
    input  logic Clk,
    input  logic arst_n_i,
    input  logic in_valid_i,
    input  T     in_data_i,
    output logic in_ready_o,
    output logic out_valid_o,
    output T     out_data_o,
    input  logic out_ready_i
);

    // Occupancy flag of the single entry
    logic valid_q;
    // Set one cycle after reset release
    logic live_q;
    T     data_q;
    logic load;

    // Free when empty or draining this cycle
    assign in_ready_o = live_q & (~valid_q | out_ready_i);
    assign load       = in_valid_i & in_ready_o;

    always_ff @(posedge Clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            live_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            live_q <= 1'b1;
            if (load) begin
                valid_q <= 1'b1;
            end else if (out_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Payload holds while the consumer stalls
    always_ff @(posedge Clk) begin
        if (load) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

/* hdl/mem_access_unit.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_access_unit (
    input  logic                 Clk,
    input  logic                 arst_n_i,
    input  logic                 req_valid_i,
    input  rv_mem_pkg::ex_mem_t  req_i,
    output logic                 req_ready_o,
    output rv_mem_pkg::wb_m2s_t  wb_m_o,
    input  rv_mem_pkg::wb_s2m_t  wb_s_i,
    output logic                 rsp_valid_o,
    output rv_mem_pkg::mem_rsp_t rsp_o,
    input  logic                 rsp_ready_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_HOLD
    } state_e;

    state_e               state_q;
    logic [1:0]           offset;
    logic                 misaligned;
    logic                 mem_access;
    logic                 accept;
    logic [`XLEN/8-1:0]   st_sel;
    logic [`XLEN-1:0]     st_dat;
    logic                 bus_we_q;
    logic [`XLEN/8-1:0]   bus_sel_q;
    logic [`XLEN-3:0]     bus_adr_q;
    logic [`XLEN-1:0]     bus_dat_q;
    rv_mem_pkg::mem_rsp_t rsp_q;

    // **********************************************************************
    // Request decode
    // **********************************************************************

    assign offset = req_i.alu_result[1:0];

    // Halfwords need even, words need zero offset
    always_comb begin
        case (req_i.op)
            rv_mem_pkg::LH, rv_mem_pkg::LHU, rv_mem_pkg::SH: misaligned = offset[0];
            rv_mem_pkg::LW, rv_mem_pkg::SW:                  misaligned = |offset;
            default:                                         misaligned = 1'b0;
        endcase
    end

    // Faulting records never touch memory
    assign mem_access = (rv_mem_pkg::is_load(req_i.op) | rv_mem_pkg::is_store(req_i.op))
                      & ~misaligned & ~req_i.exception;

    // Store lanes, data replicated so the RAM picks by select
    always_comb begin
        case (req_i.op)
            rv_mem_pkg::SB: begin
                st_dat = {4{req_i.rs2_data[7:0]}};
                st_sel = 4'b0001 << offset;
            end
            rv_mem_pkg::SH: begin
                st_dat = {2{req_i.rs2_data[15:0]}};
                st_sel = offset[1] ? 4'b1100 : 4'b0011;
            end
            rv_mem_pkg::SW: begin
                st_dat = req_i.rs2_data;
                st_sel = 4'b1111;
            end
            default: begin
                // Loads read the full word
                st_dat = '0;
                st_sel = 4'b1111;
            end
        endcase
    end

    // New request only once the held response leaves
    assign req_ready_o = (state_q == ST_IDLE) | ((state_q == ST_HOLD) & rsp_ready_i);
    assign accept      = req_valid_i & req_ready_o;

    // **********************************************************************
    // Control FSM
    // **********************************************************************

    always_ff @(posedge Clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE, ST_HOLD: begin
                    if (accept) begin
                        state_q <= mem_access ? ST_BUS : ST_HOLD;
                    end else if (state_q == ST_HOLD && rsp_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                // cyc drops on the cycle after ack
                ST_BUS: begin
                    if (wb_s_i.ack) begin
                        state_q <= ST_HOLD;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Bus fields and response payload
    always_ff @(posedge Clk) begin
        if (accept) begin
            bus_we_q         <= rv_mem_pkg::is_store(req_i.op);
            bus_sel_q        <= st_sel;
            bus_adr_q        <= req_i.alu_result[`XLEN-1:2];
            bus_dat_q        <= st_dat;
            rsp_q.op         <= req_i.op;
            rsp_q.byte_off   <= offset;
            rsp_q.alu_result <= req_i.alu_result;
            rsp_q.rd_word    <= '0;
            rsp_q.mem_to_reg <= req_i.mem_to_reg;
            // No register write from a misaligned access
            rsp_q.rf_wr_en   <= req_i.rf_wr_en & ~misaligned;
            rsp_q.rd_addr    <= req_i.rd_addr;
            rsp_q.exception  <= req_i.exception | misaligned;
        end else if (state_q == ST_BUS && wb_s_i.ack) begin
            rsp_q.rd_word <= wb_s_i.dat;
        end
    end

    assign wb_m_o.cyc  = (state_q == ST_BUS);
    assign wb_m_o.stb  = (state_q == ST_BUS);
    assign wb_m_o.we   = bus_we_q;
    assign wb_m_o.sel  = bus_sel_q;
    assign wb_m_o.adr  = bus_adr_q;
    assign wb_m_o.dat  = bus_dat_q;

    assign rsp_valid_o = (state_q == ST_HOLD);
    assign rsp_o       = rsp_q;

endmodule

/* hdl/data_ram_wb.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module data_ram_wb #(
    parameter int RAM_WORDS = 256
) (
    input  logic                Clk,
    input  logic                arst_n_i,
    input  rv_mem_pkg::wb_m2s_t wb_m_i,
    output rv_mem_pkg::wb_s2m_t wb_s_o
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [`XLEN-1:0] mem [RAM_WORDS];
    logic [AW-1:0]    idx;
    logic             new_req;
    logic             ack_q;
    logic [`XLEN-1:0] rd_q;

    // Word index wraps at the depth
    assign idx = AW'(wb_m_i.adr % RAM_WORDS);

    // Strobe not yet acknowledged
    assign new_req = wb_m_i.cyc & wb_m_i.stb & ~ack_q;

    // **********************************************************************
    // Acknowledge, one cycle per request
    // **********************************************************************

    always_ff @(posedge Clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= new_req;
        end
    end

    // Storage with byte-lane writes
    always_ff @(posedge Clk) begin
        if (new_req) begin
            // Old word on reads and stores alike
            rd_q <= mem[idx];
            if (wb_m_i.we) begin
                for (int b = 0; b < `XLEN/8; b++) begin
                    if (wb_m_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= wb_m_i.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    assign wb_s_o.ack = ack_q;
    assign wb_s_o.dat = rd_q;

endmodule

/* hdl/mem_wb_stage.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_wb_stage (
    input  logic                 Clk,
    input  logic                 arst_n_i,
    input  logic                 rsp_valid_i,
    input  rv_mem_pkg::mem_rsp_t rsp_i,
    output logic                 rsp_ready_o,
    output logic                 out_valid_o,
    output rv_mem_pkg::mem_wb_t  out_o,
    input  logic                 out_ready_i
);

    logic [7:0]          ld_byte;
    logic [15:0]         ld_half;
    logic [`XLEN-1:0]    ld_val;
    rv_mem_pkg::mem_wb_t wb_rec;

    // **********************************************************************
    // Load lane extraction
    // **********************************************************************

    // Byte lane chosen by the address offset
    always_comb begin
        case (rsp_i.byte_off)
            2'd0:    ld_byte = rsp_i.rd_word[7:0];
            2'd1:    ld_byte = rsp_i.rd_word[15:8];
            2'd2:    ld_byte = rsp_i.rd_word[23:16];
            default: ld_byte = rsp_i.rd_word[31:24];
        endcase
    end

    // Upper or lower halfword
    assign ld_half = rsp_i.byte_off[1] ? rsp_i.rd_word[31:16] : rsp_i.rd_word[15:0];

    // Sign or zero extension per op
    always_comb begin
        case (rsp_i.op)
            rv_mem_pkg::LB:  ld_val = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
            rv_mem_pkg::LH:  ld_val = {{(`XLEN-16){ld_half[15]}}, ld_half};
            rv_mem_pkg::LBU: ld_val = {{(`XLEN-8){1'b0}}, ld_byte};
            rv_mem_pkg::LHU: ld_val = {{(`XLEN-16){1'b0}}, ld_half};
            default:         ld_val = rsp_i.rd_word;
        endcase
    end

    // Writeback record assembly
    always_comb begin
        wb_rec.rd_data    = rsp_i.mem_to_reg ? ld_val : rsp_i.alu_result;
        wb_rec.alu_result = rsp_i.alu_result;
        wb_rec.rf_wr_en   = rsp_i.rf_wr_en;
        wb_rec.rd_addr    = rsp_i.rd_addr;
        wb_rec.exception  = rsp_i.exception;
    end

    // Output register toward the register file
    stage_reg #(
        .T (rv_mem_pkg::mem_wb_t)
    ) out_reg_i (
        .Clk         (Clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (rsp_valid_i),
        .in_data_i   (wb_rec),
        .in_ready_o  (rsp_ready_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_o),
        .out_ready_i (out_ready_i)
    );

endmodule

/* hdl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int RAM_WORDS = 256
) (
    input  logic                Clk,
    input  logic                arst_n_i,
    input  logic                in_valid_i,
    input  rv_mem_pkg::ex_mem_t in_i,
    output logic                in_ready_o,
    output logic                out_valid_o,
    output rv_mem_pkg::mem_wb_t out_o,
    input  logic                out_ready_i
);

    // Input register to access unit
    logic                 ex_valid;
    logic                 ex_ready;
    rv_mem_pkg::ex_mem_t  ex_rec;
    // Data bus
    rv_mem_pkg::wb_m2s_t  wb_m2s;
    rv_mem_pkg::wb_s2m_t  wb_s2m;
    // Access unit to writeback
    logic                 rsp_valid;
    logic                 rsp_ready;
    rv_mem_pkg::mem_rsp_t rsp_rec;

    // **********************************************************************
    // Pipeline: input register, access, RAM, writeback
    // **********************************************************************

    stage_reg #(
        .T (rv_mem_pkg::ex_mem_t)
    ) in_reg_i (
        .Clk         (Clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (ex_valid),
        .out_data_o  (ex_rec),
        .out_ready_i (ex_ready)
    );

    mem_access_unit mau_i (
        .Clk         (Clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (ex_valid),
        .req_i       (ex_rec),
        .req_ready_o (ex_ready),
        .wb_m_o      (wb_m2s),
        .wb_s_i      (wb_s2m),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp_rec),
        .rsp_ready_i (rsp_ready)
    );

    data_ram_wb #(
        .RAM_WORDS (RAM_WORDS)
    ) ram_i (
        .Clk      (Clk),
        .arst_n_i (arst_n_i),
        .wb_m_i   (wb_m2s),
        .wb_s_o   (wb_s2m)
    );

    mem_wb_stage wb_stage_i (
        .Clk         (Clk),
        .arst_n_i    (arst_n_i),
        .rsp_valid_i (rsp_valid),
        .rsp_i       (rsp_rec),
        .rsp_ready_o (rsp_ready),
        .out_valid_o (out_valid_o),
        .out_o       (out_o),
        .out_ready_i (out_ready_i)
    );

endmodule

/* testbench/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic Clk,
    output logic arst_n_o
);

    // Free-running clock, low for the first half period
    initial begin
        Clk = 1'b0;
        forever #(PERIOD_NS / 2) Clk = ~Clk;
    end

    // Reset held over the first rising edges, released on a falling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(negedge Clk);
        arst_n_o = 1'b1;
    end

endmodule

/* testbench/mem_subsys_sva.sv */
`timescale 1ns/1ps

module mem_subsys_sva (
    input logic                 Clk,
    input logic                 arst_n_i,
    input rv_mem_pkg::wb_m2s_t  wb_m_i,
    input rv_mem_pkg::wb_s2m_t  wb_s_i,
    input logic                 rsp_valid_i,
    input rv_mem_pkg::mem_rsp_t rsp_i,
    input logic                 rsp_ready_i
);

    // Number of failed assertions
    int fail_count = 0;

    // **********************************************************************
    // Wishbone classic rules
    // **********************************************************************

    // Strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge Clk) disable iff (!arst_n_i)
        wb_m_i.stb |-> wb_m_i.cyc)
    else begin
        $error("Wishbone stb high without cyc");
        fail_count++;
    end

    // Master frozen while the slave has not acknowledged
    master_stable: assert property (@(posedge Clk) disable iff (!arst_n_i)
        (wb_m_i.cyc && wb_m_i.stb && !wb_s_i.ack) |=>
        (wb_m_i.cyc && wb_m_i.stb &&
         $stable({wb_m_i.we, wb_m_i.sel, wb_m_i.adr, wb_m_i.dat})))
    else begin
        $error("Wishbone master signals changed before ack");
        fail_count++;
    end

    // Ack answers a live strobe
    ack_needs_stb: assert property (@(posedge Clk) disable iff (!arst_n_i)
        wb_s_i.ack |-> (wb_m_i.cyc && wb_m_i.stb))
    else begin
        $error("Wishbone ack without stb");
        fail_count++;
    end

    // Cycle closes right after its ack
    cyc_drop: assert property (@(posedge Clk) disable iff (!arst_n_i)
        wb_s_i.ack |=> (!wb_m_i.cyc && !wb_m_i.stb))
    else begin
        $error("Wishbone cycle still open on the cycle after ack");
        fail_count++;
    end

    // Response holds under back-pressure
    rsp_hold: assert property (@(posedge Clk) disable iff (!arst_n_i)
        (rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_i)))
    else begin
        $error("response dropped or changed before it was accepted");
        fail_count++;
    end

endmodule

/* testbench/tb_mem_subsys.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module tb_mem_subsys;

    localparam int CLK_PERIOD = 100;
    localparam int RAM_WORDS  = 256;

    // One table row with its name held in name_q
    typedef struct packed {
        rv_mem_pkg::mem_op_e op;
        logic [`XLEN-1:0]    addr;
        logic [`XLEN-1:0]    data;
        logic [`XLEN-1:0]    exp_data;
        logic                exp_exc;
    } vec_t;

    logic                Clk;
    logic                arst_n;
    logic                in_valid_i;
    rv_mem_pkg::ex_mem_t in_i;
    logic                in_ready_o;
    logic                out_valid_o;
    rv_mem_pkg::mem_wb_t out_o;
    logic                out_ready_i;

    vec_t                vec_q[$];
    string               name_q[$];
    rv_mem_pkg::mem_wb_t exp_q[$];
    int                  idx_q[$];
    // Byte-wide little-endian reference memory
    logic [7:0]          ref_mem [RAM_WORDS*4];
    integer              seed;
    int                  n_entries = 0;

    clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) clk_gen_i (
        .Clk      (Clk),
        .arst_n_o (arst_n)
    );

    mem_subsys_top #(.RAM_WORDS(RAM_WORDS)) dut_i (
        .Clk         (Clk),
        .arst_n_i    (arst_n),
        .in_valid_i  (in_valid_i),
        .in_i        (in_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_o       (out_o),
        .out_ready_i (out_ready_i)
    );

    bind mem_access_unit mem_subsys_sva sva_i (
        .Clk         (Clk),
        .arst_n_i    (arst_n_i),
        .wb_m_i      (wb_m_o),
        .wb_s_i      (wb_s_i),
        .rsp_valid_i (rsp_valid_o),
        .rsp_i       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

    task automatic report_failure(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic add_vector(string name, rv_mem_pkg::mem_op_e op, logic [31:0] addr,
                              logic [31:0] data, logic [31:0] exp_data, logic exp_exc);
        vec_q.push_back({op, addr, data, exp_data, exp_exc});
        name_q.push_back(name);
    endtask

    // **********************************************************************
    // Stimulus table with hand-computed expected data
    // **********************************************************************

    task automatic build_table();
        add_vector("sw_init0",  rv_mem_pkg::SW,   32'h100, 32'h1122_3344, 32'h100, 1'b0);
        add_vector("lw_back0",  rv_mem_pkg::LW,   32'h100, 32'h0,         32'h1122_3344, 1'b0);
        add_vector("alu_pass",  rv_mem_pkg::NONE, 32'hdead_beef, 32'h0,   32'hdead_beef, 1'b0);
        add_vector("sw_init1",  rv_mem_pkg::SW,   32'h104, 32'h0,         32'h104, 1'b0);
        add_vector("sb_off0",   rv_mem_pkg::SB,   32'h104, 32'h0000_00a5, 32'h104, 1'b0);
        add_vector("sb_off1",   rv_mem_pkg::SB,   32'h105, 32'hffff_ff5a, 32'h105, 1'b0);
        add_vector("sb_off2",   rv_mem_pkg::SB,   32'h106, 32'h0000_0081, 32'h106, 1'b0);
        add_vector("sb_off3",   rv_mem_pkg::SB,   32'h107, 32'h1234_567f, 32'h107, 1'b0);
        add_vector("lw_sb",     rv_mem_pkg::LW,   32'h104, 32'h0,         32'h7f81_5aa5, 1'b0);
        add_vector("sw_init2",  rv_mem_pkg::SW,   32'h108, 32'hffff_ffff, 32'h108, 1'b0);
        add_vector("sh_off2",   rv_mem_pkg::SH,   32'h10a, 32'h0000_8001, 32'h10a, 1'b0);
        add_vector("lw_sh_hi",  rv_mem_pkg::LW,   32'h108, 32'h0,         32'h8001_ffff, 1'b0);
        add_vector("sh_off0",   rv_mem_pkg::SH,   32'h108, 32'hcafe_1234, 32'h108, 1'b0);
        add_vector("lw_sh_lo",  rv_mem_pkg::LW,   32'h108, 32'h0,         32'h8001_1234, 1'b0);
        add_vector("lb_off1",   rv_mem_pkg::LB,   32'h105, 32'h0,         32'h0000_005a, 1'b0);
        add_vector("lb_off2",   rv_mem_pkg::LB,   32'h106, 32'h0,         32'hffff_ff81, 1'b0);
        add_vector("lbu_off2",  rv_mem_pkg::LBU,  32'h106, 32'h0,         32'h0000_0081, 1'b0);
        add_vector("lb_off0",   rv_mem_pkg::LB,   32'h104, 32'h0,         32'hffff_ffa5, 1'b0);
        add_vector("lbu_off3",  rv_mem_pkg::LBU,  32'h107, 32'h0,         32'h0000_007f, 1'b0);
        add_vector("lh_off2",   rv_mem_pkg::LH,   32'h10a, 32'h0,         32'hffff_8001, 1'b0);
        add_vector("lhu_off2",  rv_mem_pkg::LHU,  32'h10a, 32'h0,         32'h0000_8001, 1'b0);
        add_vector("lh_off0",   rv_mem_pkg::LH,   32'h108, 32'h0,         32'h0000_1234, 1'b0);
        add_vector("lhu_off0",  rv_mem_pkg::LHU,  32'h100, 32'h0,         32'h0000_3344, 1'b0);
        // Misaligned accesses leave rd_data unchecked
        add_vector("sh_misal",  rv_mem_pkg::SH,   32'h101, 32'h0000_ffff, 32'h0, 1'b1);
        add_vector("lh_misal",  rv_mem_pkg::LH,   32'h103, 32'h0,         32'h0, 1'b1);
        add_vector("sw_misal",  rv_mem_pkg::SW,   32'h102, 32'h0,         32'h0, 1'b1);
        add_vector("lhu_misal", rv_mem_pkg::LHU,  32'h105, 32'h0,         32'h0, 1'b1);
        add_vector("lw_misal",  rv_mem_pkg::LW,   32'h10a, 32'h0,         32'h0, 1'b1);
        add_vector("lw_check",  rv_mem_pkg::LW,   32'h100, 32'h0,         32'h1122_3344, 1'b0);
        add_vector("lb_off3",   rv_mem_pkg::LB,   32'h103, 32'h0,         32'h0000_0011, 1'b0);
        add_vector("alu_pass2", rv_mem_pkg::NONE, 32'h1234_5678, 32'h0,   32'h1234_5678, 1'b0);
    endtask

    function automatic logic reads_mem(rv_mem_pkg::mem_op_e op);
        case (op)
            rv_mem_pkg::LB, rv_mem_pkg::LH, rv_mem_pkg::LW,
            rv_mem_pkg::LBU, rv_mem_pkg::LHU: return 1'b1;
            default:                          return 1'b0;
        endcase
    endfunction

    function automatic logic writes_mem(rv_mem_pkg::mem_op_e op);
        case (op)
            rv_mem_pkg::SB, rv_mem_pkg::SH, rv_mem_pkg::SW: return 1'b1;
            default:                                        return 1'b0;
        endcase
    endfunction

    function automatic rv_mem_pkg::ex_mem_t make_record(vec_t v, int idx);
        rv_mem_pkg::ex_mem_t r;
        r.op         = v.op;
        r.alu_result = v.addr;
        r.rs2_data   = v.data;
        r.mem_to_reg = reads_mem(v.op);
        r.rf_wr_en   = !writes_mem(v.op);
        r.rd_addr    = 5'((idx % 31) + 1);
        r.exception  = 1'b0;
        return r;
    endfunction

    function automatic int byte_at(logic [31:0] addr, int k);
        return int'((addr + 32'(k)) % 32'(RAM_WORDS * 4));
    endfunction

    // **********************************************************************
    // Reference model applied in input order
    // **********************************************************************

    function automatic rv_mem_pkg::mem_wb_t model_apply(vec_t v, logic [4:0] rd);
        rv_mem_pkg::mem_wb_t e;
        logic                misal;
        int                  b0;
        int                  b1;
        int                  b2;
        int                  b3;
        b0 = byte_at(v.addr, 0);
        b1 = byte_at(v.addr, 1);
        b2 = byte_at(v.addr, 2);
        b3 = byte_at(v.addr, 3);
        // Halfwords on even bytes and words on word boundaries
        case (v.op)
            rv_mem_pkg::LH, rv_mem_pkg::LHU, rv_mem_pkg::SH: misal = v.addr[0];
            rv_mem_pkg::LW, rv_mem_pkg::SW:                  misal = (v.addr[1:0] != 2'b00);
            default:                                         misal = 1'b0;
        endcase
        e.alu_result = v.addr;
        e.rd_addr    = rd;
        e.exception  = misal;
        e.rf_wr_en   = !writes_mem(v.op) && !misal;
        e.rd_data    = v.addr;
        if (!misal) begin
            case (v.op)
                rv_mem_pkg::LB:  e.rd_data = {{24{ref_mem[b0][7]}}, ref_mem[b0]};
                rv_mem_pkg::LBU: e.rd_data = {24'h0, ref_mem[b0]};
                rv_mem_pkg::LH:  e.rd_data = {{16{ref_mem[b1][7]}}, ref_mem[b1], ref_mem[b0]};
                rv_mem_pkg::LHU: e.rd_data = {16'h0, ref_mem[b1], ref_mem[b0]};
                rv_mem_pkg::LW: begin
                    e.rd_data = {ref_mem[b3], ref_mem[b2], ref_mem[b1], ref_mem[b0]};
                end
                rv_mem_pkg::SB:  ref_mem[b0] = v.data[7:0];
                rv_mem_pkg::SH: begin
                    ref_mem[b0] = v.data[7:0];
                    ref_mem[b1] = v.data[15:8];
                end
                rv_mem_pkg::SW: begin
                    ref_mem[b0] = v.data[7:0];
                    ref_mem[b1] = v.data[15:8];
                    ref_mem[b2] = v.data[23:16];
                    ref_mem[b3] = v.data[31:24];
                end
                default: ;
            endcase
        end
        return e;
    endfunction

    task automatic check_value(string test, string field, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("MISMATCH %s %s: expected %h, actual %h",
                                     test, field, exp, act));
        end
    endtask

    // Scoreboard check for one output transfer
    task automatic check_output();
        rv_mem_pkg::mem_wb_t exp;
        string               test;
        assert (exp_q.size() > 0) else begin
            report_failure("a record came out that was never sent");
        end
        exp  = exp_q.pop_front();
        test = name_q[idx_q.pop_front()];
        check_value(test, "exception", 32'(exp.exception), 32'(out_o.exception));
        check_value(test, "rf_wr_en", 32'(exp.rf_wr_en), 32'(out_o.rf_wr_en));
        check_value(test, "rd_addr", 32'(exp.rd_addr), 32'(out_o.rd_addr));
        check_value(test, "alu_result", exp.alu_result, out_o.alu_result);
        if (!exp.exception) begin
            check_value(test, "rd_data", exp.rd_data, out_o.rd_data);
        end
    endtask

    // Watchdog sized from the table length
    initial begin
        wait (n_entries > 0);
        #(n_entries * 20 * CLK_PERIOD);
        report_failure("watchdog expired before all records came out");
    end

    initial begin : main
        rv_mem_pkg::mem_wb_t exp;
        vec_t                v;
        int                  sent;
        int                  rcvd;
        seed        = 32'hfbe6_c3b8;
        in_valid_i  = 1'b0;
        in_i        = '0;
        out_ready_i = 1'b0;
        sent        = 0;
        rcvd        = 0;
        build_table();
        n_entries = vec_q.size();
        @(posedge arst_n);
        // Output stays quiet while idle after reset
        repeat (3) begin
            @(negedge Clk);
            out_ready_i = 1'b1;
            #(CLK_PERIOD / 4);
            assert (out_valid_o === 1'b0) else begin
                report_failure("out_valid_o is not low after reset");
            end
        end
        while (rcvd < n_entries) begin
            @(negedge Clk);
            out_ready_i = (($random(seed) & 3) != 0);
            in_valid_i  = (sent < n_entries);
            if (sent < n_entries) begin
                in_i = make_record(vec_q[sent], sent);
            end
            // Sample a quarter period later once settled
            #(CLK_PERIOD / 4);
            if (sent == 0) begin
                assert (out_valid_o === 1'b0) else begin
                    report_failure("out_valid_o rose before any record was accepted");
                end
            end
            if (out_valid_o === 1'b1 && out_ready_i) begin
                check_output();
                rcvd++;
            end
            if (in_valid_i && in_ready_o === 1'b1) begin
                v   = vec_q[sent];
                exp = model_apply(v, in_i.rd_addr);
                assert (exp.exception === v.exp_exc &&
                        (exp.exception || exp.rd_data === v.exp_data)) else begin
                    report_failure($sformatf("table entry %s disagrees with the reference model",
                                             name_q[sent]));
                end
                exp_q.push_back(exp);
                idx_q.push_back(sent);
                sent++;
            end
            assert (dut_i.mau_i.sva_i.fail_count == 0) else begin
                report_failure("a bus or handshake assertion fired");
            end
        end
        // Nothing left to come out
        in_valid_i = 1'b0;
        repeat (5) begin
            @(negedge Clk);
            out_ready_i = 1'b1;
            #(CLK_PERIOD / 4);
            assert (out_valid_o === 1'b0) else begin
                report_failure("an extra record came out after the last one");
            end
        end
        if (dut_i.mau_i.sva_i.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_failure("a bus or handshake assertion fired");
        end
    end

endmodule

/* project.f */
+incdir+include
hdl/rv_mem_pkg.sv
hdl/stage_reg.sv
hdl/mem_access_unit.sv
hdl/data_ram_wb.sv
hdl/mem_wb_stage.sv
hdl/mem_subsys_top.sv
testbench/clk_gen.sv
testbench/mem_subsys_sva.sv
testbench/tb_mem_subsys.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_mem_subsys
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
